//--- rtl/ex_pkg.sv
// Execute stage package with sizes, opcode enums, instruction views and packet types
`default_nettype none

package ex_pkg;

	////////////////////////////////////////////////////////////
	// Sizes

	localparam int XLEN       = 32;
	localparam int ALU_NUM    = 2;
	localparam int CDB_WIDTH  = 2;   // Write-back slots per cycle
	localparam int MUL_STAGES = 4;
	localparam int TAG_WIDTH  = 6;   // Physical destination tag
	localparam int ALU_IDX_W  = (ALU_NUM > 1) ? $clog2(ALU_NUM) : 1;
	localparam int MUL_CHUNK  = 2 * XLEN / MUL_STAGES;  // Multiplier bits eaten per stage

	////////////////////////////////////////////////////////////
	// Operation encodings

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_func_e;

	typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_NPC, OPA_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
	} opb_sel_e;

	////////////////////////////////////////////////////////////
	// Instruction word, one view per RV32 format

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;   // Branch condition
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} rv32_inst_u;

	////////////////////////////////////////////////////////////
	// Packets

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
		rv32_inst_u           inst;
		logic [XLEN-1:0]      pc;
		logic [XLEN-1:0]      npc;
		logic [XLEN-1:0]      rs1_value;
		logic [XLEN-1:0]      rs2_value;
		opa_sel_e             opa_sel;
		opb_sel_e             opb_sel;
		alu_func_e            alu_func;
		logic                 cond_branch;
		logic                 uncond_branch;   // JAL and JALR
		logic                 pred_taken;
		logic [XLEN-1:0]      pred_target;
	} issue_pkt_t;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
		mul_func_e            mul_func;
		logic [XLEN-1:0]      rs1_value;
		logic [XLEN-1:0]      rs2_value;
	} mul_issue_t;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
		logic [XLEN-1:0]      value;
		logic                 is_branch;
		logic                 taken;
		logic                 mispredict;
		logic [XLEN-1:0]      target;
	} cdb_pkt_t;

endpackage

`default_nettype wire

//--- rtl/operand_select.sv
// Operand A and B selection with immediate decode for one ALU lane
`timescale 1ns/1ps
`default_nettype none

module operand_select import ex_pkg::*; (
	input  issue_pkt_t      pkt,
	output logic [XLEN-1:0] opa,
	output logic [XLEN-1:0] opb
);

	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	// Sign-extended immediates, one per format view
	assign imm_i = {{(XLEN-12){pkt.inst.i.imm[11]}}, pkt.inst.i.imm};
	assign imm_s = {{(XLEN-12){pkt.inst.s.imm_hi[6]}}, pkt.inst.s.imm_hi, pkt.inst.s.imm_lo};
	assign imm_b = {{(XLEN-12){pkt.inst.b.imm12}}, pkt.inst.b.imm11,
		pkt.inst.b.imm10_5, pkt.inst.b.imm4_1, 1'b0};
	assign imm_u = {pkt.inst.u.imm, 12'b0};   // Upper 20 bits, low bits clear
	assign imm_j = {{(XLEN-20){pkt.inst.j.imm20}}, pkt.inst.j.imm19_12,
		pkt.inst.j.imm11, pkt.inst.j.imm10_1, 1'b0};

	always_comb begin
		case (pkt.opa_sel)
			OPA_RS1:  opa = pkt.rs1_value;
			OPA_PC:   opa = pkt.pc;
			OPA_NPC:  opa = pkt.npc;
			OPA_ZERO: opa = '0;
			default:  opa = '0;
		endcase
	end

	always_comb begin
		case (pkt.opb_sel)
			OPB_RS2:   opb = pkt.rs2_value;
			OPB_I_IMM: opb = imm_i;
			OPB_S_IMM: opb = imm_s;
			OPB_B_IMM: opb = imm_b;
			OPB_U_IMM: opb = imm_u;
			OPB_J_IMM: opb = imm_j;
			default:   opb = '0;   // Codes 6 and 7 unused
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
// Integer ALU with branch resolution and misprediction check
`timescale 1ns/1ps
`default_nettype none

module int_alu import ex_pkg::*; (
	input  issue_pkt_t      pkt,
	input  logic [XLEN-1:0] opa,
	input  logic [XLEN-1:0] opb,
	output cdb_pkt_t        result
);

	logic [XLEN-1:0]         alu_out;
	logic [XLEN-1:0]         sum;         // Branch and jump target
	logic [$clog2(XLEN)-1:0] shamt;
	logic                    cond_true;

	assign sum   = opa + opb;
	assign shamt = opb[$clog2(XLEN)-1:0];

	always_comb begin
		case (pkt.alu_func)
			ALU_ADD:  alu_out = sum;
			ALU_SUB:  alu_out = opa - opb;
			ALU_AND:  alu_out = opa & opb;
			ALU_OR:   alu_out = opa | opb;
			ALU_XOR:  alu_out = opa ^ opb;
			ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, opa < opb};
			ALU_SLL:  alu_out = opa << shamt;
			ALU_SRL:  alu_out = opa >> shamt;
			ALU_SRA:  alu_out = $unsigned($signed(opa) >>> shamt);
			default:  alu_out = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Branch condition from funct3

	always_comb begin
		case (pkt.inst.b.funct3)
			3'b000:  cond_true = pkt.rs1_value == pkt.rs2_value;                    // BEQ
			3'b001:  cond_true = pkt.rs1_value != pkt.rs2_value;                    // BNE
			3'b100:  cond_true = $signed(pkt.rs1_value) < $signed(pkt.rs2_value);   // BLT
			3'b101:  cond_true = $signed(pkt.rs1_value) >= $signed(pkt.rs2_value);  // BGE
			3'b110:  cond_true = pkt.rs1_value < pkt.rs2_value;                     // BLTU
			3'b111:  cond_true = pkt.rs1_value >= pkt.rs2_value;                    // BGEU
			default: cond_true = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Result packet

	always_comb begin
		result       = '0;
		result.valid = pkt.valid;
		result.tag   = pkt.tag;
		result.value = alu_out;
		if (pkt.uncond_branch) begin
			// Jumps write the link address
			result.is_branch  = 1'b1;
			result.taken      = 1'b1;
			result.value      = pkt.npc;
			result.target     = sum;
			result.mispredict = sum != pkt.pred_target;
		end else if (pkt.cond_branch) begin
			result.is_branch  = 1'b1;
			result.taken      = cond_true;
			result.target     = cond_true ? sum : pkt.npc;   // Fall through on not taken
			result.mispredict = cond_true != pkt.pred_taken;
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu_lane.sv
// One ALU lane that holds its op until the CDB takes the result
`timescale 1ns/1ps
`default_nettype none

module alu_lane import ex_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  issue_pkt_t issue,
	input  logic       grant,
	output logic       busy,
	output cdb_pkt_t   req
);

	issue_pkt_t      held;         // Op sitting in the lane
	logic            held_valid;
	issue_pkt_t      cur;
	logic            load;
	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;

	// Take a new op when empty or when the held result leaves this cycle
	assign load = ~held_valid | grant;
	assign busy = held_valid & ~grant;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (load) begin
			held_valid <= issue.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (load && issue.valid) begin
			held <= issue;
		end
	end

	always_comb begin
		cur       = held;
		cur.valid = held_valid;
	end

	operand_select u_opsel (
		.pkt (cur),
		.opa (opa),
		.opb (opb)
	);

	int_alu u_alu (
		.pkt    (cur),
		.opa    (opa),
		.opb    (opb),
		.result (req)
	);

	// Arbiter only grants lanes that ask
	assert property (@(posedge clock) disable iff (reset) grant |-> req.valid);

endmodule

`default_nettype wire

//--- rtl/mult_pipe.sv
// Pipelined 32x32 multiplier for MUL, MULH, MULHSU and MULHU with tag tracking
`timescale 1ns/1ps
`default_nettype none

module mult_pipe import ex_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  mul_issue_t issue,
	output cdb_pkt_t   result
);

	logic                  sign_a;
	logic                  sign_b;

	// Stage inputs
	logic [TAG_WIDTH-1:0]  tag_in    [MUL_STAGES];
	mul_func_e             func_in   [MUL_STAGES];
	logic [2*XLEN-1:0]     mcand_in  [MUL_STAGES];
	logic [2*XLEN-1:0]     mplier_in [MUL_STAGES];
	logic [2*XLEN-1:0]     prod_in   [MUL_STAGES];

	// Stage registers
	logic [MUL_STAGES-1:0] vld;
	logic [TAG_WIDTH-1:0]  tag_q     [MUL_STAGES];
	mul_func_e             func_q    [MUL_STAGES];
	logic [2*XLEN-1:0]     prod_q    [MUL_STAGES];
	logic [2*XLEN-1:0]     mcand_q   [MUL_STAGES-1];
	logic [2*XLEN-1:0]     mplier_q  [MUL_STAGES-1];

	// rs1 is signed except for MULHU, rs2 only for MUL and MULH
	assign sign_a = issue.mul_func != MUL_MULHU;
	assign sign_b = (issue.mul_func == MUL_MUL) || (issue.mul_func == MUL_MULH);

	always_comb begin
		tag_in[0]    = issue.tag;
		func_in[0]   = issue.mul_func;
		mcand_in[0]  = {{XLEN{sign_a & issue.rs1_value[XLEN-1]}}, issue.rs1_value};
		mplier_in[0] = {{XLEN{sign_b & issue.rs2_value[XLEN-1]}}, issue.rs2_value};
		prod_in[0]   = '0;
		for (int s = 1; s < MUL_STAGES; s++) begin
			tag_in[s]    = tag_q[s-1];
			func_in[s]   = func_q[s-1];
			mcand_in[s]  = mcand_q[s-1];
			mplier_in[s] = mplier_q[s-1];
			prod_in[s]   = prod_q[s-1];
		end
	end

	////////////////////////////////////////////////////////////
	// Pipeline, one multiplier chunk per stage

	always_ff @(posedge clock) begin
		if (reset) begin
			vld <= '0;
		end else begin
			vld <= {vld[MUL_STAGES-2:0], issue.valid};
		end
	end

	always_ff @(posedge clock) begin
		for (int s = 0; s < MUL_STAGES; s++) begin
			tag_q[s]  <= tag_in[s];
			func_q[s] <= func_in[s];
			prod_q[s] <= prod_in[s] + mcand_in[s] *
				{{(2*XLEN-MUL_CHUNK){1'b0}}, mplier_in[s][MUL_CHUNK-1:0]};
			if (s < MUL_STAGES - 1) begin
				mcand_q[s]  <= mcand_in[s] << MUL_CHUNK;   // Line up with next chunk
				mplier_q[s] <= mplier_in[s] >> MUL_CHUNK;
			end
		end
	end

	// Low word for MUL, high word otherwise
	always_comb begin
		result       = '0;
		result.valid = vld[MUL_STAGES-1];
		result.tag   = tag_q[MUL_STAGES-1];
		if (func_q[MUL_STAGES-1] == MUL_MUL) begin
			result.value = prod_q[MUL_STAGES-1][XLEN-1:0];
		end else begin
			result.value = prod_q[MUL_STAGES-1][2*XLEN-1:XLEN];
		end
	end

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
// Round-robin CDB arbiter, multiplier first, then ALU lanes into free slots
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import ex_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  cdb_pkt_t   [ALU_NUM-1:0]   alu_req,
	input  cdb_pkt_t                   mul_req,
	output logic       [ALU_NUM-1:0]   alu_grant,
	output cdb_pkt_t   [CDB_WIDTH-1:0] cdb
);

	logic [ALU_IDX_W-1:0] ptr;          // Lane that gets first pick
	logic [ALU_IDX_W-1:0] ptr_next;
	logic [ALU_IDX_W-1:0] last_lane;
	logic                 any_grant;

	always_comb begin
		int unsigned used;
		int unsigned lane;
		cdb       = '0;
		alu_grant = '0;
		used      = 0;
		last_lane = ptr;
		any_grant = 1'b0;
		// Multiplier cannot stall
		if (mul_req.valid) begin
			cdb[0] = mul_req;
			used   = 1;
		end
		for (int i = 0; i < ALU_NUM; i++) begin
			lane = (int'(ptr) + i) % ALU_NUM;
			if (alu_req[lane].valid && used < CDB_WIDTH) begin
				alu_grant[lane] = 1'b1;
				cdb[used]       = alu_req[lane];
				used            = used + 1;
				last_lane       = ALU_IDX_W'(lane);
				any_grant       = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Rotation pointer

	always_comb begin
		if (!any_grant) begin
			ptr_next = ptr;
		end else if (last_lane == ALU_IDX_W'(ALU_NUM - 1)) begin
			ptr_next = '0;   // Wrap
		end else begin
			ptr_next = last_lane + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ptr <= '0;
		end else begin
			ptr <= ptr_next;
		end
	end

	// Never more winners than slots
	assert property (@(posedge clock) disable iff (reset)
		$countones(alu_grant) + mul_req.valid <= CDB_WIDTH);

	// Tags come from the issuer and must stay unique on the bus
	for (genvar s0 = 0; s0 < CDB_WIDTH; s0++) begin : g_tag_a
		for (genvar s1 = s0 + 1; s1 < CDB_WIDTH; s1++) begin : g_tag_b
			assert property (@(posedge clock) disable iff (reset)
				cdb[s0].valid && cdb[s1].valid |-> cdb[s0].tag != cdb[s1].tag);
		end
	end

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
// Execute stage top with two ALU lanes, the multiplier and the CDB arbiter
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  issue_pkt_t [ALU_NUM-1:0]   alu_issue,
	input  mul_issue_t                 mul_issue,
	output logic       [ALU_NUM-1:0]   alu_busy,
	output cdb_pkt_t   [CDB_WIDTH-1:0] cdb
);

	cdb_pkt_t [ALU_NUM-1:0] alu_req;     // Lane results waiting for a slot
	logic     [ALU_NUM-1:0] alu_grant;
	cdb_pkt_t               mul_res;

	////////////////////////////////////////////////////////////
	// ALU lanes

	for (genvar i = 0; i < ALU_NUM; i++) begin : g_lane
		alu_lane u_lane (
			.clock (clock),
			.reset (reset),
			.issue (alu_issue[i]),
			.grant (alu_grant[i]),
			.busy  (alu_busy[i]),
			.req   (alu_req[i])
		);
	end

	mult_pipe u_mult (
		.clock  (clock),
		.reset  (reset),
		.issue  (mul_issue),
		.result (mul_res)
	);

	cdb_arbiter u_arb (
		.clock     (clock),
		.reset     (reset),
		.alu_req   (alu_req),
		.mul_req   (mul_res),
		.alu_grant (alu_grant),
		.cdb       (cdb)
	);

endmodule

`default_nettype wire

//--- verif/ex_ref_model.svh
// Reference model of the execute stage that predicts CDB packets from issue packets
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Operands with immediates cut straight from the RV32 bit layout

function automatic logic [XLEN-1:0] model_operand_a(issue_pkt_t p);
	case (p.opa_sel)
		OPA_RS1: return p.rs1_value;
		OPA_PC:  return p.pc;
		OPA_NPC: return p.npc;
		default: return '0;
	endcase
endfunction

function automatic logic [XLEN-1:0] model_operand_b(issue_pkt_t p);
	logic [31:0] w;
	w = p.inst;
	case (p.opb_sel)
		OPB_RS2:   return p.rs2_value;
		OPB_I_IMM: return {{20{w[31]}}, w[31:20]};
		OPB_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
		OPB_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		OPB_U_IMM: return {w[31:12], 12'h000};
		OPB_J_IMM: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		default:   return '0;   // Undefined select
	endcase
endfunction

function automatic logic [XLEN-1:0] model_alu_op(alu_func_e f, logic [XLEN-1:0] a,
	logic [XLEN-1:0] b);
	logic [4:0] sh;
	sh = b[4:0];
	case (f)
		ALU_ADD:  return a + b;
		ALU_SUB:  return a - b;
		ALU_AND:  return a & b;
		ALU_OR:   return a | b;
		ALU_XOR:  return a ^ b;
		ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
		ALU_SLTU: return (a < b) ? 1 : 0;
		ALU_SLL:  return a << sh;
		ALU_SRL:  return a >> sh;
		ALU_SRA:  return $signed(a) >>> sh;
		default:  return '0;
	endcase
endfunction

// BEQ BNE BLT BGE BLTU BGEU
function automatic logic model_branch_cond(logic [2:0] f3, logic [XLEN-1:0] x,
	logic [XLEN-1:0] y);
	case (f3)
		3'd0:    return x == y;
		3'd1:    return x != y;
		3'd4:    return $signed(x) < $signed(y);
		3'd5:    return $signed(x) >= $signed(y);
		3'd6:    return x < y;
		3'd7:    return x >= y;
		default: return 1'b0;
	endcase
endfunction

////////////////////////////////////////////////////////////
// Expected CDB packets

function automatic cdb_pkt_t model_alu_result(issue_pkt_t p);
	cdb_pkt_t        r;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic            c;
	a = model_operand_a(p);
	b = model_operand_b(p);
	c = model_branch_cond(p.inst[14:12], p.rs1_value, p.rs2_value);
	r = '0;
	r.valid = 1'b1;
	r.tag   = p.tag;
	r.value = model_alu_op(p.alu_func, a, b);
	if (p.uncond_branch) begin
		r.is_branch  = 1'b1;
		r.taken      = 1'b1;
		r.value      = p.npc;   // Link address
		r.target     = a + b;
		r.mispredict = (a + b) != p.pred_target;
	end else if (p.cond_branch) begin
		r.is_branch  = 1'b1;
		r.taken      = c;
		r.target     = c ? a + b : p.npc;
		r.mispredict = c != p.pred_taken;
	end
	return r;
endfunction

function automatic cdb_pkt_t model_mul_result(mul_issue_t m);
	cdb_pkt_t    r;
	longint      x;
	longint      y;
	logic [63:0] full;
	// Extend each operand by its own signedness, then one 64-bit product
	if (m.mul_func == MUL_MULHU) begin
		x = longint'(m.rs1_value);
	end else begin
		x = longint'($signed(m.rs1_value));
	end
	if (m.mul_func == MUL_MUL || m.mul_func == MUL_MULH) begin
		y = longint'($signed(m.rs2_value));
	end else begin
		y = longint'(m.rs2_value);
	end
	full = x * y;
	r = '0;
	r.valid = 1'b1;
	r.tag   = m.tag;
	r.value = (m.mul_func == MUL_MUL) ? full[31:0] : full[63:32];
	return r;
endfunction

`endif

//--- verif/ex_stage_tb.sv
// Testbench for the execute stage with random issue and a tag-based CDB scoreboard
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

	localparam int RESET_CYCLES = 4;
	localparam int NUM_OPS      = 2000;
	localparam int ISSUE_LIMIT  = 20000;   // Cycles allowed for the issue phase
	localparam int DRAIN_LIMIT  = 200;

	logic                       clock;
	logic                       reset;
	issue_pkt_t [ALU_NUM-1:0]   alu_issue;
	mul_issue_t                 mul_issue;
	logic       [ALU_NUM-1:0]   alu_busy;
	cdb_pkt_t   [CDB_WIDTH-1:0] cdb;

	cdb_pkt_t             expected [int];   // Outstanding results by tag
	int                   mul_due  [int];
	int                   mul_tag_q[$];
	int                   mul_due_q[$];
	int                   tag_pool [$];
	logic [ALU_NUM-1:0]   accept_alu;
	logic [ALU_NUM-1:0]   lane_pending;      // Lane holds a result not yet on the cdb
	logic [TAG_WIDTH-1:0] lane_tag [ALU_NUM];
	int                   busy_run [ALU_NUM];
	int                   cycle;
	int                   issued;
	bit                   started;

	`include "ex_ref_model.svh"

	ex_stage dut (
		.clock     (clock),
		.reset     (reset),
		.alu_issue (alu_issue),
		.mul_issue (mul_issue),
		.alu_busy  (alu_busy),
		.cdb       (cdb)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	function automatic issue_pkt_t random_alu_issue(int tag);
		issue_pkt_t p;
		cdb_pkt_t   guess;
		int         kind;
		p = '0;
		p.valid         = 1'b1;
		p.tag           = TAG_WIDTH'(tag);
		p.inst          = $urandom;
		p.pc            = $urandom & 32'hffff_fffc;
		p.npc           = p.pc + 4;
		p.rs1_value     = $urandom;
		p.rs2_value     = ($urandom_range(0, 3) == 0) ? p.rs1_value : $urandom;
		p.opa_sel       = opa_sel_e'($urandom_range(0, 3));
		p.opb_sel       = opb_sel_e'($urandom_range(0, 7));   // 6 and 7 undefined
		p.alu_func      = alu_func_e'($urandom_range(0, 9));
		kind            = $urandom_range(0, 9);
		p.cond_branch   = (kind == 7) || (kind == 8);
		p.uncond_branch = kind == 9;
		p.pred_taken    = $urandom_range(0, 1);
		p.pred_target   = $urandom;
		guess = model_alu_result(p);
		if ($urandom_range(0, 1) == 1) begin
			p.pred_target = guess.target;   // Correct jump prediction
		end
		return p;
	endfunction

	function automatic mul_issue_t random_mul_issue(int tag);
		mul_issue_t m;
		m.valid     = 1'b1;
		m.tag       = TAG_WIDTH'(tag);
		m.mul_func  = mul_func_e'($urandom_range(0, 3));
		m.rs1_value = ($urandom_range(0, 7) == 0) ? 32'h8000_0000 : $urandom;
		m.rs2_value = ($urandom_range(0, 7) == 0) ? 32'hffff_ffff : $urandom;
		return m;
	endfunction

	// Busy lanes keep their packet, free lanes get a new one or go idle
	task automatic drive_cycle(input bit allow_new);
		issue_pkt_t [ALU_NUM-1:0] next_alu;
		mul_issue_t               next_mul;
		next_alu = alu_issue;
		for (int l = 0; l < ALU_NUM; l++) begin
			if (!alu_issue[l].valid || accept_alu[l]) begin
				if (allow_new && tag_pool.size() > 0 && $urandom_range(0, 3) != 0) begin
					next_alu[l] = random_alu_issue(tag_pool.pop_front());
				end else begin
					next_alu[l] = '0;
				end
			end
		end
		if (allow_new && tag_pool.size() > 0 && $urandom_range(0, 2) != 0) begin
			next_mul = random_mul_issue(tag_pool.pop_front());
		end else begin
			next_mul = '0;
		end
		alu_issue <= next_alu;
		mul_issue <= next_mul;
	endtask

	function automatic bit outstanding();
		bit pend;
		pend = expected.num() != 0 || mul_issue.valid;
		for (int l = 0; l < ALU_NUM; l++) begin
			pend = pend || alu_issue[l].valid;
		end
		return pend;
	endfunction

	////////////////////////////////////////////////////////////
	// Scoreboard

	task automatic score_cdb();
		int       t;
		string    at;
		cdb_pkt_t exp;
		for (int s = 0; s < CDB_WIDTH; s++) begin
			if (cdb[s].valid) begin
				t = cdb[s].tag;
				if (!expected.exists(t)) begin
					abort_run($sformatf("Tag %0d appeared on cdb slot %0d but was not outstanding",
						t, s));
				end
				exp = expected[t];
				at  = $sformatf("cdb[%0d] tag %0d", s, t);
				check_value({at, " value"}, cdb[s].value, exp.value);
				check_value({at, " is_branch"}, cdb[s].is_branch, exp.is_branch);
				check_value({at, " taken"}, cdb[s].taken, exp.taken);
				check_value({at, " mispredict"}, cdb[s].mispredict, exp.mispredict);
				check_value({at, " target"}, cdb[s].target, exp.target);
				if (mul_due.exists(t)) begin
					check_value({at, " multiplier cycle"}, 64'(cycle), 64'(mul_due[t]));
					check_value({at, " multiplier slot"}, 64'(s), 64'd0);
					mul_due.delete(t);
				end
				expected.delete(t);
				tag_pool.push_back(t);
			end
		end
		// Multiplier results may never slip
		while (mul_due_q.size() > 0 && mul_due_q[0] <= cycle) begin
			if (mul_due.exists(mul_tag_q[0])) begin
				abort_run($sformatf("Multiplier result for tag %0d missing in cycle %0d",
					mul_tag_q[0], mul_due_q[0]));
			end
			void'(mul_tag_q.pop_front());
			void'(mul_due_q.pop_front());
		end
	endtask

	always @(negedge clock) begin
		bit on_bus;
		cycle = cycle + 1;
		if (reset || !started) begin
			accept_alu   = '0;
			lane_pending = '0;
			for (int s = 0; s < CDB_WIDTH; s++) begin
				check_value($sformatf("cdb[%0d].valid", s), cdb[s].valid, 1'b0);
			end
			check_value("alu_busy", alu_busy, '0);
		end else begin
			// A lane is busy while its held result stays off the cdb
			for (int l = 0; l < ALU_NUM; l++) begin
				on_bus = 1'b0;
				for (int s = 0; s < CDB_WIDTH; s++) begin
					on_bus = on_bus || (cdb[s].valid && cdb[s].tag == lane_tag[l]);
				end
				check_value($sformatf("alu_busy[%0d]", l), alu_busy[l],
					lane_pending[l] && !on_bus);
				if (on_bus) begin
					lane_pending[l] = 1'b0;
				end
			end
			score_cdb();
			for (int l = 0; l < ALU_NUM; l++) begin
				busy_run[l] = alu_busy[l] ? busy_run[l] + 1 : 0;
				if (busy_run[l] >= ALU_NUM) begin
					abort_run($sformatf("Lane %0d stayed busy for %0d cycles", l, busy_run[l]));
				end
				// Accepted at the coming edge
				accept_alu[l] = alu_issue[l].valid && !alu_busy[l];
				if (accept_alu[l]) begin
					expected[alu_issue[l].tag] = model_alu_result(alu_issue[l]);
					lane_pending[l] = 1'b1;
					lane_tag[l]     = alu_issue[l].tag;
					issued = issued + 1;
				end
			end
			if (mul_issue.valid) begin
				expected[mul_issue.tag] = model_mul_result(mul_issue);
				mul_due[mul_issue.tag]  = cycle + MUL_STAGES;
				mul_tag_q.push_back(mul_issue.tag);
				mul_due_q.push_back(cycle + MUL_STAGES);
				issued = issued + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int wait_cycles;
		void'($urandom(89));
		clock        = 1'b0;
		reset        = 1'b1;
		alu_issue    = '0;
		mul_issue    = '0;
		accept_alu   = '0;
		lane_pending = '0;
		cycle        = 0;
		issued       = 0;
		started      = 1'b0;
		for (int t = 0; t < (1 << TAG_WIDTH); t++) begin
			tag_pool.push_back(t);
		end
		for (int l = 0; l < ALU_NUM; l++) begin
			busy_run[l] = 0;
			lane_tag[l] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		started = 1'b1;

		wait_cycles = 0;
		while (issued < NUM_OPS) begin
			if (wait_cycles == ISSUE_LIMIT) begin
				abort_run($sformatf("Timeout while issuing, only %0d ops accepted", issued));
			end
			drive_cycle(1'b1);
			@(posedge clock);
			wait_cycles++;
		end

		// Drain everything still in flight
		wait_cycles = 0;
		while (outstanding()) begin
			if (wait_cycles == DRAIN_LIMIT) begin
				abort_run($sformatf("Timeout while draining, %0d results never reached the cdb",
					expected.num()));
			end
			drive_cycle(1'b0);
			@(posedge clock);
			wait_cycles++;
		end
		repeat (MUL_STAGES + 2) @(posedge clock);   // Stray results would hit the scoreboard
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
rtl/ex_pkg.sv
rtl/operand_select.sv
rtl/int_alu.sv
rtl/alu_lane.sv
rtl/mult_pipe.sv
rtl/cdb_arbiter.sv
rtl/ex_stage.sv
verif/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - rtl/ex_pkg.sv
  - rtl/operand_select.sv
  - rtl/int_alu.sv
  - rtl/alu_lane.sv
  - rtl/mult_pipe.sv
  - rtl/cdb_arbiter.sv
  - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ex_stage_tb.sv
